//--- Makefile
# Verilator flow for the SoC subsystem

TOP := tb_soc_subsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module soc_subsystem -f soc_subsystem.f

sim:
	verilator --binary --timing --top-module $(TOP) -f soc_subsystem.f -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- bench/tb_soc_subsystem.sv
/*
 * Testbench for the SoC subsystem. Walks a table of bus accesses through the
 * four-phase master port, checks the debug hold-off after reset and runs the
 * CLINT time base from rtc_i to check the timer and software interrupts.
 */

`timescale 1ns/10ps

module tb_soc_subsystem;
  import soc_pkg::*;

  localparam int unsigned NUM_HARTS    = 2;
  localparam int unsigned HOLDOFF      = 40;
  localparam int unsigned NUM_ROWS     = 41;
  localparam data_t       MTIME_BASE   = 64'h0000_0000_0000_1000;
  localparam int unsigned MTIME_STEPS  = 3;
  localparam data_t       MTIME_END    = MTIME_BASE + data_t'(MTIME_STEPS);
  localparam int unsigned RTC_EDGES    = 2 * MTIME_STEPS;
  localparam int unsigned TIMEOUT      = 20 * NUM_ROWS + 8 * RTC_EDGES + HOLDOFF + 200;
  localparam addr_t       MTIMECMP0    = CLINT_BASE + CLINT_MTIMECMP_OFF;
  localparam addr_t       MTIMECMP1    = CLINT_BASE + CLINT_MTIMECMP_OFF + 32'h8;
  localparam addr_t       MSIP         = CLINT_BASE + CLINT_MSIP_OFF;
  localparam addr_t       MTIME        = CLINT_BASE + CLINT_MTIME_OFF;

  typedef struct packed {
    logic  wr;
    addr_t addr;
    data_t wdata;
    data_t rdata;
    logic  err;
  } row_t;

  logic                 clk_i = 1'b0;
  logic                 ndmreset_n;
  logic                 rtc_i;
  logic                 req_i;
  bus_req_t             bus_req_i;
  logic                 ack_o;
  bus_rsp_t             bus_rsp_o;
  logic [NUM_HARTS-1:0] debug_req_i;
  logic [NUM_HARTS-1:0] debug_req_o;
  logic [NUM_HARTS-1:0] timer_irq_o;
  logic [NUM_HARTS-1:0] soft_irq_o;

  row_t        rows [NUM_ROWS];
  int unsigned n_rows = 0;
  int unsigned cycles = 0;

  soc_subsystem #(
    .NUM_HARTS            ( NUM_HARTS ),
    .DEBUG_HOLDOFF_CYCLES ( HOLDOFF   )
  ) dut (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( req_i       ),
    .bus_req_i   ( bus_req_i   ),
    .ack_o       ( ack_o       ),
    .bus_rsp_o   ( bus_rsp_o   ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .timer_irq_o ( timer_irq_o ),
    .soft_irq_o  ( soft_irq_o  )
  );

  always #5 clk_i = ~clk_i;

  // Run limit in clock cycles
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Something failed");
      $fatal(1, "Timeout: no end of test after %0d clock cycles", TIMEOUT);
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
      $display("Something failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic add_row(input logic is_wr, input addr_t address, input data_t wr_data,
                         input data_t exp_rdata, input logic exp_err);
    rows[n_rows] = '{wr: is_wr, addr: address, wdata: wr_data, rdata: exp_rdata, err: exp_err};
    n_rows++;
  endtask

  // One full four-phase access on the master port
  task automatic bus_access(input logic is_wr, input addr_t address, input data_t wr_data,
                            output bus_rsp_t rsp);
    @(posedge clk_i);
    req_i     <= 1'b1;
    bus_req_i <= '{addr: address, we: is_wr, wdata: wr_data};
    @(negedge clk_i);
    while (!ack_o) @(negedge clk_i);
    rsp = bus_rsp_o;
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    while (ack_o) @(negedge clk_i);
  endtask

  // Write responses carry no read data
  task automatic run_rows(input int unsigned first, input int unsigned last);
    bus_rsp_t rsp;
    for (int unsigned i = first; i <= last; i++) begin
      bus_access(rows[i].wr, rows[i].addr, rows[i].wdata, rsp);
      compare($sformatf("bus_rsp_o.err (row %0d)", i), 64'(rsp.err), 64'(rows[i].err));
      if (!rows[i].wr) begin
        compare($sformatf("bus_rsp_o.rdata (row %0d)", i), rsp.rdata, rows[i].rdata);
      end
    end
  endtask

  task automatic check_irqs(input logic [NUM_HARTS-1:0] exp_soft,
                            input logic [NUM_HARTS-1:0] exp_timer);
    repeat (3) @(negedge clk_i);
    compare("soft_irq_o", 64'(soft_irq_o), 64'(exp_soft));
    compare("timer_irq_o", 64'(timer_irq_o), 64'(exp_timer));
  endtask

  // Each level of rtc_i is held for 4 clock cycles
  task automatic apply_rtc_edges(input int unsigned n);
    @(posedge clk_i);
    repeat (n) begin
      rtc_i <= 1'b1;
      repeat (4) @(posedge clk_i);
      rtc_i <= 1'b0;
      repeat (4) @(posedge clk_i);
    end
  endtask

  task automatic check_holdoff();
    for (int unsigned i = 0; i < HOLDOFF; i++) begin
      @(negedge clk_i);
      compare($sformatf("debug_req_o (cycle %0d)", i), 64'(debug_req_o), 64'(0));
    end
    @(negedge clk_i);
    compare("debug_req_o (after hold-off)", 64'(debug_req_o), 64'(2'b11));
    // Once open, each hart's line follows its own request
    for (int unsigned v = 0; v < (1 << NUM_HARTS); v++) begin
      @(posedge clk_i);
      debug_req_i <= v[NUM_HARTS-1:0];
      @(negedge clk_i);
      compare($sformatf("debug_req_o (request %0d)", v), 64'(debug_req_o), 64'(v));
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus table
  // --------------------------------------------------------------------------
  task automatic build_table();
    // Boot image and the words past its end
    for (int unsigned i = 0; i < ROM_WORDS; i++) begin
      add_row(1'b0, ROM_BASE + addr_t'(8 * i), '0, BOOT_IMAGE[i], 1'b0);
    end
    add_row(1'b0, ROM_BASE + 32'h40, '0, '0, 1'b0);
    add_row(1'b0, ROM_BASE + 32'hFF8, '0, '0, 1'b0);
    add_row(1'b1, ROM_BASE + 32'h8, 64'h0123_4567_89AB_CDEF, '0, 1'b1);
    add_row(1'b0, ROM_BASE + 32'h8, '0, BOOT_IMAGE[1], 1'b0);
    // Unmapped addresses
    add_row(1'b0, 32'h0000_0000, '0, '0, 1'b1);
    add_row(1'b0, 32'h0300_0000, '0, '0, 1'b1);
    add_row(1'b0, CLINT_BASE + 32'hC000, '0, '0, 1'b1);
    add_row(1'b0, ROM_BASE + 32'h1000, '0, '0, 1'b1);
    add_row(1'b1, 32'h0300_0000, 64'h55, '0, 1'b1);
    // Compare registers and bad CLINT offsets
    add_row(1'b0, MTIMECMP0, '0, '1, 1'b0);
    add_row(1'b0, MTIMECMP1, '0, '1, 1'b0);
    add_row(1'b1, MTIMECMP0, 64'h0000_0001_0000_0000, '0, 1'b0);
    add_row(1'b0, MTIMECMP0, '0, 64'h0000_0001_0000_0000, 1'b0);
    add_row(1'b1, MTIMECMP1, 64'h0000_0002_0000_0000, '0, 1'b0);
    add_row(1'b0, MTIMECMP1, '0, 64'h0000_0002_0000_0000, 1'b0);
    add_row(1'b0, CLINT_BASE + 32'h10, '0, '0, 1'b1);
    add_row(1'b1, CLINT_BASE + 32'h4010, 64'h7, '0, 1'b1);
    add_row(1'b0, MTIMECMP0, '0, 64'h0000_0001_0000_0000, 1'b0);
    add_row(1'b0, MTIME, '0, '0, 1'b0);
    // Software interrupt bits
    add_row(1'b1, MSIP, 64'h3, '0, 1'b0);
    add_row(1'b0, MSIP, '0, 64'h3, 1'b0);
    add_row(1'b1, MSIP, 64'h2, '0, 1'b0);
    add_row(1'b0, MSIP, '0, 64'h2, 1'b0);
    add_row(1'b1, MSIP, 64'h0, '0, 1'b0);
    add_row(1'b0, MSIP, '0, 64'h0, 1'b0);
    // Time base and timer interrupts
    add_row(1'b1, MTIME, MTIME_BASE, '0, 1'b0);
    add_row(1'b1, MTIMECMP0, MTIME_END, '0, 1'b0);
    add_row(1'b1, MTIMECMP1, MTIME_END - 1, '0, 1'b0);
    add_row(1'b0, MTIME, '0, MTIME_END, 1'b0);
    add_row(1'b1, MTIMECMP0, MTIME_END + 1, '0, 1'b0);
    add_row(1'b1, MTIMECMP1, '1, '0, 1'b0);
    add_row(1'b1, MTIMECMP0, MTIME_BASE, '0, 1'b0);
    add_row(1'b0, MTIMECMP0, '0, MTIME_BASE, 1'b0);
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    ndmreset_n  = 1'b0;
    rtc_i       = 1'b0;
    req_i       = 1'b0;
    bus_req_i   = '0;
    debug_req_i = '1;

    build_table();
    if (n_rows != NUM_ROWS) begin
      $display("Something failed");
      $fatal(1, "The stimulus table holds %0d rows instead of %0d", n_rows, NUM_ROWS);
    end

    repeat (8) @(posedge clk_i);
    ndmreset_n <= 1'b1;
    check_holdoff();

    run_rows(0, 26);
    check_irqs(2'b00, 2'b00);
    run_rows(27, 27);
    check_irqs(2'b11, 2'b00);
    run_rows(28, 29);
    check_irqs(2'b10, 2'b00);
    run_rows(30, 31);
    check_irqs(2'b00, 2'b00);

    // Both compare values above mtime before the rtc runs
    run_rows(32, 35);
    check_irqs(2'b00, 2'b00);
    apply_rtc_edges(RTC_EDGES);
    run_rows(36, 36);
    check_irqs(2'b00, 2'b11);
    run_rows(37, 37);
    check_irqs(2'b00, 2'b10);
    run_rows(38, 38);
    check_irqs(2'b00, 2'b00);
    run_rows(39, 39);
    check_irqs(2'b00, 2'b01);
    run_rows(40, 40);

    $display("Everything OK");
    $finish;
  end

endmodule

//--- soc_subsystem.f
source/soc_pkg.sv
source/bus_router.sv
source/boot_rom.sv
source/clint.sv
source/debug_holdoff.sv
source/soc_subsystem.sv
bench/tb_soc_subsystem.sv

//--- source/boot_rom.sv
/*
 * Read-only boot image on the internal bus. Reads return the image word at
 * the offset's word index; writes are refused with an error.
 */

`timescale 1ns/10ps

module boot_rom (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              req_i,
  input  soc_pkg::bus_req_t bus_req_i,
  output logic              ack_o,
  output soc_pkg::bus_rsp_t bus_rsp_o
);
  import soc_pkg::*;

  localparam int unsigned IDX_W = $clog2(ROM_WORDS);

  addr_t    word_idx;
  bus_rsp_t rsp_d, rsp_q;
  logic     ack_q;

  always_comb begin : p_read
    word_idx    = bus_req_i.addr >> 3;
    rsp_d.rdata = '0;
    rsp_d.err   = bus_req_i.we;
    // Past the end of the image reads as zero
    if (!bus_req_i.we && word_idx < addr_t'(ROM_WORDS)) begin
      rsp_d.rdata = BOOT_IMAGE[word_idx[IDX_W-1:0]];
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_ack
    if (!ndmreset_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin : p_rsp
    if (req_i && !ack_q) rsp_q <= rsp_d;
  end

  assign ack_o     = ack_q;
  assign bus_rsp_o = rsp_q;

endmodule

//--- source/bus_router.sv
/*
 * Address-decoding router between the single bus master and the two targets.
 * Runs a four-phase req/ack handshake on both sides, one access at a time,
 * and answers unmapped addresses itself with an error.
 */

`timescale 1ns/10ps

module bus_router (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  // Master side
  input  logic              req_i,
  input  soc_pkg::bus_req_t bus_req_i,
  output logic              ack_o,
  output soc_pkg::bus_rsp_t bus_rsp_o,
  // Target side
  output logic              rom_req_o,
  output logic              clint_req_o,
  output soc_pkg::bus_req_t tgt_req_o,
  input  logic              rom_ack_i,
  input  soc_pkg::bus_rsp_t rom_rsp_i,
  input  logic              clint_ack_i,
  input  soc_pkg::bus_rsp_t clint_rsp_i
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    FORWARD,
    RESPOND,
    RELEASE
  } state_e;

  state_e   state_d, state_q;
  target_e  target_q;
  target_e  dec_target;
  addr_t    dec_offset;
  bus_req_t tgt_req_q;
  bus_rsp_t rsp_q;
  logic     sel_ack;
  bus_rsp_t sel_rsp;

  // --------------------------------------------------------------------------
  // Decode against the rule table
  // --------------------------------------------------------------------------
  always_comb begin : p_decode
    dec_target = TARGET_NONE;
    dec_offset = '0;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (bus_req_i.addr >= ADDR_MAP[i].base &&
          (bus_req_i.addr - ADDR_MAP[i].base) < ADDR_MAP[i].size) begin
        dec_target = ADDR_MAP[i].target;
        dec_offset = bus_req_i.addr - ADDR_MAP[i].base;
      end
    end
  end

  // Ack and response of whichever target is in use
  always_comb begin : p_select
    sel_ack = 1'b0;
    sel_rsp = '0;
    case (target_q)
      TARGET_ROM: begin
        sel_ack = rom_ack_i;
        sel_rsp = rom_rsp_i;
      end
      TARGET_CLINT: begin
        sel_ack = clint_ack_i;
        sel_rsp = clint_rsp_i;
      end
      default: ;
    endcase
  end

  // --------------------------------------------------------------------------
  // Handshake FSM
  // --------------------------------------------------------------------------
  always_comb begin : p_next
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          state_d = (dec_target == TARGET_NONE) ? RESPOND : FORWARD;
        end
      end
      FORWARD: begin
        if (sel_ack) state_d = RESPOND;
      end
      RESPOND: begin
        // Target may still be releasing its ack
        if (!req_i) state_d = sel_ack ? RELEASE : IDLE;
      end
      RELEASE: begin
        if (!sel_ack) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_state
    if (!ndmreset_n) begin
      state_q  <= IDLE;
      target_q <= TARGET_NONE;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && req_i) target_q <= dec_target;
    end
  end

  // Captured request and returned response
  always_ff @(posedge clk_i) begin : p_payload
    if (state_q == IDLE && req_i) begin
      tgt_req_q.addr  <= dec_offset;
      tgt_req_q.we    <= bus_req_i.we;
      tgt_req_q.wdata <= bus_req_i.wdata;
      if (dec_target == TARGET_NONE) begin
        rsp_q.rdata <= '0;
        rsp_q.err   <= 1'b1;
      end
    end else if (state_q == FORWARD && sel_ack) begin
      rsp_q <= sel_rsp;
    end
  end

  assign rom_req_o   = (state_q == FORWARD) && (target_q == TARGET_ROM);
  assign clint_req_o = (state_q == FORWARD) && (target_q == TARGET_CLINT);
  assign tgt_req_o   = tgt_req_q;
  assign ack_o       = (state_q == RESPOND) || (state_q == RELEASE);
  assign bus_rsp_o   = rsp_q;

endmodule

//--- source/clint.sv
/*
 * Core-local interruptor: machine time driven by rtc_i divided by two,
 * one compare register and one software interrupt bit per hart.
 * Registers sit at the package offsets, relative to the CLINT base.
 */

`timescale 1ns/10ps

module clint #(
  parameter int unsigned NUM_HARTS = 2
) (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic                 rtc_i,
  input  logic                 req_i,
  input  soc_pkg::bus_req_t    bus_req_i,
  output logic                 ack_o,
  output soc_pkg::bus_rsp_t    bus_rsp_o,
  output logic [NUM_HARTS-1:0] timer_irq_o,
  output logic [NUM_HARTS-1:0] soft_irq_o
);
  import soc_pkg::*;

  logic [2:0]           rtc_q;
  logic                 rtc_rise;
  logic                 div_q;
  data_t                mtime_q;
  data_t                mtimecmp_q [NUM_HARTS];
  logic [NUM_HARTS-1:0] msip_q;
  logic [NUM_HARTS-1:0] timer_irq_q;
  logic                 ack_q;
  logic                 access;
  logic                 hit_msip;
  logic                 hit_mtime;
  logic [NUM_HARTS-1:0] hit_cmp;
  bus_rsp_t             rsp_d, rsp_q;

  // --------------------------------------------------------------------------
  // rtc sampling and tick divider
  // --------------------------------------------------------------------------
  // Two synchronizer stages, third stage only for edge detection
  assign rtc_rise = rtc_q[1] & ~rtc_q[2];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_rtc
    if (!ndmreset_n) begin
      rtc_q <= '0;
      div_q <= 1'b0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
      if (rtc_rise) div_q <= ~div_q;
    end
  end

  // --------------------------------------------------------------------------
  // Register decode
  // --------------------------------------------------------------------------
  assign access = req_i & ~ack_q;

  always_comb begin : p_decode
    hit_msip  = 1'b0;
    hit_mtime = 1'b0;
    hit_cmp   = '0;
    rsp_d     = '{rdata: '0, err: 1'b1};
    if (bus_req_i.addr == CLINT_MSIP_OFF) begin
      hit_msip    = 1'b1;
      rsp_d.rdata = data_t'(msip_q);
      rsp_d.err   = 1'b0;
    end
    if (bus_req_i.addr == CLINT_MTIME_OFF) begin
      hit_mtime   = 1'b1;
      rsp_d.rdata = mtime_q;
      rsp_d.err   = 1'b0;
    end
    for (int h = 0; h < NUM_HARTS; h++) begin
      if (bus_req_i.addr == CLINT_MTIMECMP_OFF + addr_t'(8 * h)) begin
        hit_cmp[h]  = 1'b1;
        rsp_d.rdata = mtimecmp_q[h];
        rsp_d.err   = 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Timer and interrupt state
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_regs
    if (!ndmreset_n) begin
      ack_q       <= 1'b0;
      mtime_q     <= '0;
      msip_q      <= '0;
      timer_irq_q <= '0;
      for (int h = 0; h < NUM_HARTS; h++) begin
        mtimecmp_q[h] <= '1;
      end
    end else begin
      ack_q <= req_i;
      // A bus write wins over the rtc increment
      if (access && bus_req_i.we && hit_mtime) begin
        mtime_q <= bus_req_i.wdata;
      end else if (rtc_rise && div_q) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (access && bus_req_i.we && hit_msip) begin
        msip_q <= bus_req_i.wdata[NUM_HARTS-1:0];
      end
      for (int h = 0; h < NUM_HARTS; h++) begin
        if (access && bus_req_i.we && hit_cmp[h]) mtimecmp_q[h] <= bus_req_i.wdata;
        timer_irq_q[h] <= (mtime_q >= mtimecmp_q[h]);
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_rsp
    if (access) rsp_q <= rsp_d;
  end

  assign ack_o       = ack_q;
  assign bus_rsp_o   = rsp_q;
  assign timer_irq_o = timer_irq_q;
  assign soft_irq_o  = msip_q;

endmodule

//--- source/debug_holdoff.sv
/*
 * Keeps the debug request vector low for a fixed number of cycles after
 * reset, so the boot code runs before the first debug halt.
 */

`timescale 1ns/10ps

module debug_holdoff #(
  parameter int unsigned NUM_HARTS            = 2,
  parameter int unsigned DEBUG_HOLDOFF_CYCLES = 500
) (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic [NUM_HARTS-1:0] debug_req_i,
  output logic [NUM_HARTS-1:0] debug_req_o
);

  // One spare value so a zero hold-off still gets a legal width
  localparam int unsigned CNT_W = $clog2(DEBUG_HOLDOFF_CYCLES + 2);

  typedef logic [CNT_W-1:0] holdoff_cnt_t;

  holdoff_cnt_t cnt_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_cnt
    if (!ndmreset_n) begin
      cnt_q <= holdoff_cnt_t'(DEBUG_HOLDOFF_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - holdoff_cnt_t'(1);
    end
  end

  // Pass through once run down
  assign debug_req_o = (cnt_q == '0) ? debug_req_i : '0;

endmodule

//--- source/soc_pkg.sv
/*
 * Shared types and constants for the SoC subsystem: bus widths and structs,
 * the address decode rules, CLINT register offsets and the boot ROM image.
 * Imported by the router, the targets and the top level.
 */

package soc_pkg;

  // --------------------------------------------------------------------------
  // Bus types
  // --------------------------------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    TARGET_ROM,
    TARGET_CLINT,
    TARGET_NONE
  } target_e;

  typedef struct packed {
    target_e target;
    addr_t   base;
    addr_t   size;
  } addr_rule_t;

  localparam addr_t ROM_BASE   = 32'h0001_0000;
  localparam addr_t ROM_SIZE   = 32'h0000_1000;
  localparam addr_t CLINT_BASE = 32'h0200_0000;
  localparam addr_t CLINT_SIZE = 32'h0000_C000;

  localparam int unsigned NUM_RULES = 2;

  localparam addr_rule_t ADDR_MAP [NUM_RULES] = '{
    '{target: TARGET_ROM,   base: ROM_BASE,   size: ROM_SIZE},
    '{target: TARGET_CLINT, base: CLINT_BASE, size: CLINT_SIZE}
  };

  // CLINT register offsets, relative to CLINT_BASE
  localparam addr_t CLINT_MSIP_OFF     = 32'h0000_0000;
  localparam addr_t CLINT_MTIMECMP_OFF = 32'h0000_4000;
  localparam addr_t CLINT_MTIME_OFF    = 32'h0000_BFF8;

  // --------------------------------------------------------------------------
  // Boot image
  // --------------------------------------------------------------------------
  localparam int unsigned ROM_WORDS = 8;

  // Short start-up stub, two instructions per word
  localparam data_t BOOT_IMAGE [ROM_WORDS] = '{
    64'hF140_2573_0000_0297,
    64'h0202_8593_0000_0417,
    64'h1050_0073_0004_0067,
    64'hFFDF_F06F_0000_0013,
    64'h8000_0537_0000_0513,
    64'h3055_1073_0080_0593,
    64'h0000_0000_3045_9073,
    64'hDEAD_BEEF_CAFE_F00D
  };

endpackage

//--- source/soc_subsystem.sv
/*
 * Top level of the subsystem. Connects the bus router to the boot ROM and
 * the CLINT, and gates the debug request through the hold-off counter.
 */

`timescale 1ns/10ps

module soc_subsystem #(
  parameter int unsigned NUM_HARTS            = 2,
  parameter int unsigned DEBUG_HOLDOFF_CYCLES = 500
) (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic                 rtc_i,
  // Bus master port
  input  logic                 req_i,
  input  soc_pkg::bus_req_t    bus_req_i,
  output logic                 ack_o,
  output soc_pkg::bus_rsp_t    bus_rsp_o,
  // Per-hart lines
  input  logic [NUM_HARTS-1:0] debug_req_i,
  output logic [NUM_HARTS-1:0] debug_req_o,
  output logic [NUM_HARTS-1:0] timer_irq_o,
  output logic [NUM_HARTS-1:0] soft_irq_o
);
  import soc_pkg::*;

  logic     rom_req;
  logic     clint_req;
  bus_req_t tgt_req;
  logic     rom_ack;
  bus_rsp_t rom_rsp;
  logic     clint_ack;
  bus_rsp_t clint_rsp;

  // --------------------------------------------------------------------------
  // Bus router
  // --------------------------------------------------------------------------
  bus_router i_bus_router (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( req_i       ),
    .bus_req_i   ( bus_req_i   ),
    .ack_o       ( ack_o       ),
    .bus_rsp_o   ( bus_rsp_o   ),
    .rom_req_o   ( rom_req     ),
    .clint_req_o ( clint_req   ),
    .tgt_req_o   ( tgt_req     ),
    .rom_ack_i   ( rom_ack     ),
    .rom_rsp_i   ( rom_rsp     ),
    .clint_ack_i ( clint_ack   ),
    .clint_rsp_i ( clint_rsp   )
  );

  // --------------------------------------------------------------------------
  // Targets
  // --------------------------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( rom_req    ),
    .bus_req_i  ( tgt_req    ),
    .ack_o      ( rom_ack    ),
    .bus_rsp_o  ( rom_rsp    )
  );

  clint #(
    .NUM_HARTS ( NUM_HARTS )
  ) i_clint (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .bus_req_i   ( tgt_req     ),
    .ack_o       ( clint_ack   ),
    .bus_rsp_o   ( clint_rsp   ),
    .timer_irq_o ( timer_irq_o ),
    .soft_irq_o  ( soft_irq_o  )
  );

  // Debug request gating
  debug_holdoff #(
    .NUM_HARTS            ( NUM_HARTS            ),
    .DEBUG_HOLDOFF_CYCLES ( DEBUG_HOLDOFF_CYCLES )
  ) i_debug_holdoff (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule
